//--- common/ulpi_pkg.sv
package ulpi_pkg;

  // Width of the ULPI data bus
  localparam int DATA_W = 8;

  // One byte on the ULPI data bus, in either direction
  typedef logic [DATA_W-1:0] ulpi_byte_t;

  // Register write commands
  // Bits 7:6 = 2'b10 mark a write, bits 5:0 hold the register address
  localparam ulpi_byte_t REG_FUNC_CTRL = 8'h84;
  localparam ulpi_byte_t REG_OTG_CTRL = 8'h8A;

  // Transmit command with a zero PID, used to drive the chirp-K
  localparam ulpi_byte_t TX_NOPID = 8'h40;

  // Function Control values
  // XcvrSelect, TermSelect and OpMode for each phase of speed negotiation
  // Full-speed, normal operation, suspendM released
  localparam ulpi_byte_t FUNC_FS = 8'h45;
  // High-speed transceiver, chirp opmode (bit stuffing and NRZI off)
  localparam ulpi_byte_t FUNC_CHIRP = 8'h54;
  // High-speed transceiver, normal operation
  localparam ulpi_byte_t FUNC_HS = 8'h40;

  // OTG Control at power-on
  // All pull-downs and VBUS drive disabled for a device-only core
  localparam ulpi_byte_t OTG_DEFAULT = 8'h00;

endpackage

//--- common/usb_link_pkg.sv
package usb_link_pkg;

  // LineState, VbusState and RxEvent from the RX CMD byte
  typedef logic [1:0] line_state_t;

  // LineState encodings
  localparam line_state_t LS_SE0 = 2'd0;
  localparam line_state_t LS_J = 2'd1;
  localparam line_state_t LS_K = 2'd2;

  // Timer counter, wide enough for the full-size counts
  typedef logic [9:0] timer_count_t;

  // Line timer counts, scaled down for simulation
  // Full size at 60 MHz: 150 clocks, 40 ticks, 400 ticks
  localparam int TICK_COUNT = 8;
  localparam int TICKS_100US = 4;
  localparam int TICKS_1MS = 6;
  localparam int MS_PER_3MS = 3;

  // K-J pairs from the host before switching to high-speed
  localparam int KJ_PAIRS = 3;

  // Speed negotiator states
  typedef enum logic [3:0] {
    POWER_ON,
    FS_START,
    FS_LSSE0,
    WAIT_SE0,
    CHIRP_K0,
    CHIRP_K1,
    CHIRP_KJ,
    HS_START,
    IDLE,
    SUSPEND,
    RESET
  } neg_state_t;

endpackage

//--- rtl/ulpi_rx_capture.sv
module ulpi_rx_capture (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      ulpi_dir_i,
  input  logic                      ulpi_nxt_i,
  input  ulpi_pkg::ulpi_byte_t      ulpi_data_i,
  output logic                      dir_q_o,
  output usb_link_pkg::line_state_t line_state_o,
  output usb_link_pkg::line_state_t vbus_state_o,
  output usb_link_pkg::line_state_t rx_event_o,
  output logic                      ls_changed_o
);

  logic                 dir_q;
  logic                 dir_qq;
  logic                 nxt_q;
  ulpi_pkg::ulpi_byte_t data_q;
  logic                 rx_cmd;

  // Pin registers, meant to sit in the IOBs
  always_ff @(posedge clock) begin
    dir_q <= ulpi_dir_i;
    dir_qq <= dir_q;
    nxt_q <= ulpi_nxt_i;
    data_q <= ulpi_data_i;
  end

  assign dir_q_o = dir_q;

  // RX CMD: PHY owned the bus on the cycle before as well (no turnaround)
  // and nxt was low, so this is status rather than receive data
  assign rx_cmd = dir_qq && dir_q && !nxt_q;

  // Status fields, J while nothing has been reported yet
  always_ff @(posedge clock) begin
    if (reset) begin
      line_state_o <= usb_link_pkg::LS_J;
      vbus_state_o <= '0;
      rx_event_o <= '0;
      ls_changed_o <= 1'b0;
    end else begin
      // Strobe lines up with the updated line_state_o
      ls_changed_o <= rx_cmd && (data_q[1:0] != line_state_o);
      if (rx_cmd) begin
        line_state_o <= data_q[1:0];
        vbus_state_o <= data_q[3:2];
        rx_event_o <= data_q[5:4];
      end
    end
  end

  // Timer restarts come only from decoded status bytes
  assert property (@(posedge clock) disable iff (reset)
    ls_changed_o |-> $past(rx_cmd));

endmodule

//--- rtl/line_timers.sv
module line_timers (
  input  logic clock,
  input  logic reset,
  input  logic ls_changed_i,
  input  logic restart_100us_i,
  output logic tick_2_5us_o,
  output logic pulse_100us_o,
  output logic pulse_1ms_o,
  output logic pulse_3ms_o
);

  // Stage order: 0 tick, 1 100 us, 2 1 ms, 3 3 ms
  logic [3:0]                 stage_en;
  logic [3:0]                 stage_clr;
  wire  [3:0]                 stage_pulse;
  usb_link_pkg::timer_count_t stage_last [4];

  // Last count value of each stage
  assign stage_last[0] = usb_link_pkg::timer_count_t'(usb_link_pkg::TICK_COUNT - 1);
  assign stage_last[1] = usb_link_pkg::timer_count_t'(usb_link_pkg::TICKS_100US - 1);
  assign stage_last[2] = usb_link_pkg::timer_count_t'(usb_link_pkg::TICKS_1MS - 1);
  assign stage_last[3] = usb_link_pkg::timer_count_t'(usb_link_pkg::MS_PER_3MS - 1);

  // Tick counts clocks, 100 us and 1 ms count ticks, 3 ms counts 1 ms pulses
  assign stage_en = {stage_pulse[2], stage_pulse[0], stage_pulse[0], 1'b1};

  // Only the 100 us stage ignores the line, it belongs to the negotiator
  assign stage_clr = {ls_changed_i, ls_changed_i, restart_100us_i, ls_changed_i};

  for (genvar i = 0; i < 4; i++) begin : g_stage
    usb_link_pkg::timer_count_t count_q;
    logic                       pulse_q;

    always_ff @(posedge clock) begin
      if (reset || stage_clr[i]) begin
        count_q <= '0;
        pulse_q <= 1'b0;
      end else begin
        pulse_q <= 1'b0;
        if (stage_en[i]) begin
          // Wrap and fire once per full period
          if (count_q == stage_last[i]) begin
            count_q <= '0;
            pulse_q <= 1'b1;
          end else begin
            count_q <= count_q + 1'b1;
          end
        end
      end
    end

    assign stage_pulse[i] = pulse_q;
  end

  assign tick_2_5us_o = stage_pulse[0];
  assign pulse_100us_o = stage_pulse[1];
  assign pulse_1ms_o = stage_pulse[2];
  assign pulse_3ms_o = stage_pulse[3];

  // 3 ms pulse always trails a 1 ms pulse by one clock
  assert property (@(posedge clock) disable iff (reset)
    pulse_3ms_o |-> $past(pulse_1ms_o));

endmodule

//--- speed_negotiator/speed_negotiator.sv
module speed_negotiator (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      bus_busy_i,
  input  usb_link_pkg::line_state_t line_state_i,
  input  logic                      ls_changed_i,
  input  logic                      tick_2_5us_i,
  input  logic                      pulse_100us_i,
  input  logic                      pulse_1ms_i,
  input  logic                      pulse_3ms_i,
  input  logic                      done_i,
  output logic                      write_o,
  output logic                      nopid_o,
  output logic                      stop_o,
  output ulpi_pkg::ulpi_byte_t      addr_o,
  output ulpi_pkg::ulpi_byte_t      value_o,
  output logic                      restart_100us_o,
  output logic                      high_speed_o,
  output logic                      usb_reset_o,
  output logic                      suspend_o
);

  usb_link_pkg::neg_state_t state_q;
  logic                     hs_mode_q;
  logic [2:0]               kj_count_q;
  logic                     kj_valid_q;
  logic                     kj_done;

  // High-speed only counts once back in IDLE
  assign high_speed_o = (state_q == usb_link_pkg::IDLE) && hs_mode_q;
  assign suspend_o = state_q == usb_link_pkg::SUSPEND;

  // Enough pairs seen and the last symbol held for a full tick
  assign kj_done = (kj_count_q == 3'(usb_link_pkg::KJ_PAIRS)) && kj_valid_q;

  // Host chirp counter
  // Each change to J closes one K-J pair
  always_ff @(posedge clock) begin
    if (reset || state_q != usb_link_pkg::CHIRP_KJ) begin
      kj_count_q <= '0;
      kj_valid_q <= 1'b0;
    end else begin
      // A symbol is valid once it has been stable for 2.5 us
      if (ls_changed_i) begin
        kj_valid_q <= 1'b0;
      end else if (tick_2_5us_i) begin
        kj_valid_q <= 1'b1;
      end
      if (ls_changed_i && line_state_i == usb_link_pkg::LS_J &&
          kj_count_q != 3'(usb_link_pkg::KJ_PAIRS)) begin
        kj_count_q <= kj_count_q + 3'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_link_pkg::POWER_ON;
      write_o <= 1'b0;
      nopid_o <= 1'b0;
      stop_o <= 1'b0;
      restart_100us_o <= 1'b0;
      hs_mode_q <= 1'b0;
      usb_reset_o <= 1'b0;
    end else begin
      // One-cycle strobes
      stop_o <= 1'b0;
      restart_100us_o <= 1'b0;
      // Hold still while the PHY owns the bus, but never lose a done
      if (!bus_busy_i || done_i) begin
        case (state_q)
          usb_link_pkg::POWER_ON: begin
            write_o <= 1'b1;
            addr_o <= ulpi_pkg::REG_OTG_CTRL;
            value_o <= ulpi_pkg::OTG_DEFAULT;
            // Chain straight into the full-speed write
            if (done_i) begin
              state_q <= usb_link_pkg::FS_START;
              addr_o <= ulpi_pkg::REG_FUNC_CTRL;
              value_o <= ulpi_pkg::FUNC_FS;
            end
          end

          usb_link_pkg::FS_START: begin
            hs_mode_q <= 1'b0;
            write_o <= 1'b1;
            addr_o <= ulpi_pkg::REG_FUNC_CTRL;
            value_o <= ulpi_pkg::FUNC_FS;
            if (done_i) begin
              write_o <= 1'b0;
              restart_100us_o <= 1'b1;
              state_q <= usb_link_pkg::FS_LSSE0;
            end
          end

          // SE0 from the host starts the chirp, otherwise settle in full-speed
          usb_link_pkg::FS_LSSE0: begin
            if (line_state_i == usb_link_pkg::LS_SE0) begin
              state_q <= usb_link_pkg::WAIT_SE0;
            end else if (pulse_100us_i) begin
              usb_reset_o <= 1'b0;
              state_q <= usb_link_pkg::IDLE;
            end
          end

          usb_link_pkg::WAIT_SE0: begin
            if (ls_changed_i) begin
              state_q <= usb_link_pkg::FS_LSSE0;
            end else if (tick_2_5us_i) begin
              // Steady SE0, switch the transceiver to chirp mode
              write_o <= 1'b1;
              addr_o <= ulpi_pkg::REG_FUNC_CTRL;
              value_o <= ulpi_pkg::FUNC_CHIRP;
              state_q <= usb_link_pkg::CHIRP_K0;
            end
          end

          usb_link_pkg::CHIRP_K0: begin
            if (done_i) begin
              write_o <= 1'b0;
              nopid_o <= 1'b1;
              state_q <= usb_link_pkg::CHIRP_K1;
            end
          end

          // Chirp-K runs until the 1 ms timer fires
          usb_link_pkg::CHIRP_K1: begin
            if (done_i) begin
              nopid_o <= 1'b0;
            end
            if (pulse_1ms_i && !nopid_o) begin
              stop_o <= 1'b1;
              state_q <= usb_link_pkg::CHIRP_KJ;
            end
          end

          usb_link_pkg::CHIRP_KJ: begin
            if (kj_done && line_state_i == usb_link_pkg::LS_J) begin
              write_o <= 1'b1;
              addr_o <= ulpi_pkg::REG_FUNC_CTRL;
              value_o <= ulpi_pkg::FUNC_HS;
              state_q <= usb_link_pkg::HS_START;
            end
          end

          usb_link_pkg::HS_START: begin
            if (done_i) begin
              write_o <= 1'b0;
              hs_mode_q <= 1'b1;
              usb_reset_o <= 1'b0;
              state_q <= usb_link_pkg::IDLE;
            end
          end

          // 3 ms of a steady line means bus reset or suspend
          usb_link_pkg::IDLE: begin
            if (pulse_3ms_i && line_state_i == usb_link_pkg::LS_SE0) begin
              usb_reset_o <= 1'b1;
              state_q <= usb_link_pkg::RESET;
            end else if (pulse_3ms_i && line_state_i == usb_link_pkg::LS_J) begin
              state_q <= usb_link_pkg::SUSPEND;
            end
          end

          usb_link_pkg::RESET: begin
            if (tick_2_5us_i) begin
              write_o <= 1'b1;
              addr_o <= ulpi_pkg::REG_FUNC_CTRL;
              value_o <= ulpi_pkg::FUNC_FS;
              state_q <= usb_link_pkg::FS_START;
            end
          end

          usb_link_pkg::SUSPEND: begin
            if (line_state_i != usb_link_pkg::LS_J) begin
              state_q <= usb_link_pkg::IDLE;
            end
          end

          default: begin
            state_q <= usb_link_pkg::POWER_ON;
          end
        endcase
      end
    end
  end

  // The transmitter handles one request kind at a time
  assert property (@(posedge clock) disable iff (reset)
    !(write_o && nopid_o));

endmodule

//--- rtl/ulpi_transmitter.sv
module ulpi_transmitter (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 ulpi_dir_i,
  input  logic                 ulpi_nxt_i,
  input  logic                 write_i,
  input  logic                 nopid_i,
  input  logic                 stop_i,
  input  ulpi_pkg::ulpi_byte_t addr_i,
  input  ulpi_pkg::ulpi_byte_t value_i,
  output ulpi_pkg::ulpi_byte_t ulpi_data_o,
  output logic                 ulpi_stp_o,
  output logic                 done_o,
  output logic                 busy_o
);

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_CMD,
    TX_VALUE,
    TX_STP,
    TX_NOPID,
    TX_TAIL,
    TX_TAIL_STP
  } tx_state_t;

  tx_state_t            state_q;
  logic                 accept;
  ulpi_pkg::ulpi_byte_t tx_byte;

  // PHY takes a byte on nxt while the link owns the bus
  assign accept = ulpi_nxt_i && !ulpi_dir_i;
  assign busy_o = ulpi_dir_i;

  always_comb begin
    case (state_q)
      TX_CMD:   tx_byte = addr_i;
      TX_VALUE: tx_byte = value_i;
      TX_NOPID: tx_byte = ulpi_pkg::TX_NOPID;
      default:  tx_byte = '0;
    endcase
  end

  // Nothing driven while the PHY owns the bus
  assign ulpi_data_o = ulpi_dir_i ? '0 : tx_byte;
  assign ulpi_stp_o = !ulpi_dir_i && (state_q == TX_STP || state_q == TX_TAIL_STP);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= TX_IDLE;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        // Request is still up during done, so skip that cycle
        TX_IDLE: begin
          if (!ulpi_dir_i && !done_o) begin
            if (write_i) begin
              state_q <= TX_CMD;
            end else if (nopid_i) begin
              state_q <= TX_NOPID;
            end
          end
        end

        TX_CMD: begin
          if (accept) begin
            state_q <= TX_VALUE;
          end
        end

        // PHY turnaround aborts the write, start over with the address
        TX_VALUE: begin
          if (ulpi_dir_i) begin
            state_q <= TX_CMD;
          end else if (accept) begin
            state_q <= TX_STP;
          end
        end

        TX_STP: begin
          if (ulpi_dir_i) begin
            state_q <= TX_CMD;
          end else begin
            done_o <= 1'b1;
            state_q <= TX_IDLE;
          end
        end

        TX_NOPID: begin
          if (accept) begin
            done_o <= 1'b1;
            state_q <= TX_TAIL;
          end
        end

        // Zero data keeps the chirp going
        TX_TAIL: begin
          if (stop_i) begin
            state_q <= TX_TAIL_STP;
          end
        end

        // Wait for the bus if the PHY grabbed it meanwhile
        TX_TAIL_STP: begin
          if (!ulpi_dir_i) begin
            state_q <= TX_IDLE;
          end
        end

        default: begin
          state_q <= TX_IDLE;
        end
      endcase
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    ulpi_dir_i |-> !ulpi_stp_o);

endmodule

//--- rtl/ulpi_line_ctrl.sv
module ulpi_line_ctrl (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      ulpi_dir_i,
  input  logic                      ulpi_nxt_i,
  input  ulpi_pkg::ulpi_byte_t      ulpi_data_i,
  output ulpi_pkg::ulpi_byte_t      ulpi_data_o,
  output logic                      ulpi_stp_o,
  output usb_link_pkg::line_state_t line_state_o,
  output usb_link_pkg::line_state_t vbus_state_o,
  output usb_link_pkg::line_state_t rx_event_o,
  output logic                      high_speed_o,
  output logic                      usb_reset_o,
  output logic                      suspend_o,
  output logic                      pulse_2_5us_o,
  output logic                      pulse_1ms_o
);

  logic                 dir_q;
  logic                 ls_changed;
  logic                 pulse_100us;
  logic                 pulse_3ms;
  logic                 restart_100us;
  logic                 write;
  logic                 nopid;
  logic                 stop;
  logic                 done;
  logic                 tx_busy;
  logic                 bus_busy;
  ulpi_pkg::ulpi_byte_t addr;
  ulpi_pkg::ulpi_byte_t value;

  // Registered dir also covers the turnaround cycle after dir falls
  assign bus_busy = dir_q | tx_busy;

  ulpi_rx_capture ulpi_rx_capture_inst (
    .clock        (clock),
    .reset        (reset),
    .ulpi_dir_i   (ulpi_dir_i),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .ulpi_data_i  (ulpi_data_i),
    .dir_q_o      (dir_q),
    .line_state_o (line_state_o),
    .vbus_state_o (vbus_state_o),
    .rx_event_o   (rx_event_o),
    .ls_changed_o (ls_changed)
  );

  line_timers line_timers_inst (
    .clock           (clock),
    .reset           (reset),
    .ls_changed_i    (ls_changed),
    .restart_100us_i (restart_100us),
    .tick_2_5us_o    (pulse_2_5us_o),
    .pulse_100us_o   (pulse_100us),
    .pulse_1ms_o     (pulse_1ms_o),
    .pulse_3ms_o     (pulse_3ms)
  );

  speed_negotiator speed_negotiator_inst (
    .clock           (clock),
    .reset           (reset),
    .bus_busy_i      (bus_busy),
    .line_state_i    (line_state_o),
    .ls_changed_i    (ls_changed),
    .tick_2_5us_i    (pulse_2_5us_o),
    .pulse_100us_i   (pulse_100us),
    .pulse_1ms_i     (pulse_1ms_o),
    .pulse_3ms_i     (pulse_3ms),
    .done_i          (done),
    .write_o         (write),
    .nopid_o         (nopid),
    .stop_o          (stop),
    .addr_o          (addr),
    .value_o         (value),
    .restart_100us_o (restart_100us),
    .high_speed_o    (high_speed_o),
    .usb_reset_o     (usb_reset_o),
    .suspend_o       (suspend_o)
  );

  ulpi_transmitter ulpi_transmitter_inst (
    .clock       (clock),
    .reset       (reset),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .write_i     (write),
    .nopid_i     (nopid),
    .stop_i      (stop),
    .addr_i      (addr),
    .value_i     (value),
    .ulpi_data_o (ulpi_data_o),
    .ulpi_stp_o  (ulpi_stp_o),
    .done_o      (done),
    .busy_o      (tx_busy)
  );

endmodule

//--- verification/ulpi_line_ctrl_tb.sv
module ulpi_line_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Cycle limit for any single wait
  localparam int WAIT_LIMIT = 2000;

  // Selectors for wait_until
  localparam int SEL_HIGH_SPEED = 0;
  localparam int SEL_USB_RESET = 1;
  localparam int SEL_SUSPEND = 2;
  localparam int SEL_PULSE_1MS = 3;

  logic                      clock;
  logic                      reset;
  logic                      ulpi_dir;
  logic                      ulpi_nxt;
  ulpi_pkg::ulpi_byte_t      ulpi_data_in;
  ulpi_pkg::ulpi_byte_t      ulpi_data_o;
  logic                      ulpi_stp_o;
  usb_link_pkg::line_state_t line_state_o;
  usb_link_pkg::line_state_t vbus_state_o;
  usb_link_pkg::line_state_t rx_event_o;
  logic                      high_speed_o;
  logic                      usb_reset_o;
  logic                      suspend_o;
  logic                      pulse_2_5us_o;
  logic                      pulse_1ms_o;

  int error_count;
  int check_count;
  int test_count;
  int test_errors;
  int seed;

  ulpi_line_ctrl ulpi_line_ctrl_inst (
    .clock         (clock),
    .reset         (reset),
    .ulpi_dir_i    (ulpi_dir),
    .ulpi_nxt_i    (ulpi_nxt),
    .ulpi_data_i   (ulpi_data_in),
    .ulpi_data_o   (ulpi_data_o),
    .ulpi_stp_o    (ulpi_stp_o),
    .line_state_o  (line_state_o),
    .vbus_state_o  (vbus_state_o),
    .rx_event_o    (rx_event_o),
    .high_speed_o  (high_speed_o),
    .usb_reset_o   (usb_reset_o),
    .suspend_o     (suspend_o),
    .pulse_2_5us_o (pulse_2_5us_o),
    .pulse_1ms_o   (pulse_1ms_o)
  );

  always #50 clock = ~clock;

  // Link must release stp whenever the PHY owns the bus
  always @(negedge clock) begin
    if (!reset && ulpi_dir && ulpi_stp_o) begin
      error_count++;
      $display("stp was high while the PHY was driving dir");
    end
  end

  task automatic abort_on_timeout(input string what);
    $display("Timeout: %s", what);
    $display("Verification failed");
    $finish;
  endtask

  task automatic check_byte(input string name, input ulpi_pkg::ulpi_byte_t got,
                            input ulpi_pkg::ulpi_byte_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_line(input string name, input usb_link_pkg::line_state_t got,
                            input usb_link_pkg::line_state_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count_value(input string name, input int got, input int exp);
    check_count++;
    if (got != exp) begin
      error_count++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clock);
    #10;
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == test_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_count - test_errors);
    end
    test_errors = error_count;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    ulpi_dir = 1'b0;
    ulpi_nxt = 1'b0;
    ulpi_data_in = '0;
    repeat (2) @(posedge clock);
    #10;
    reset = 1'b0;
  endtask

  function automatic logic watch(input int sel);
    case (sel)
      SEL_HIGH_SPEED: watch = high_speed_o;
      SEL_USB_RESET:  watch = usb_reset_o;
      SEL_SUSPEND:    watch = suspend_o;
      default:        watch = pulse_1ms_o;
    endcase
  endfunction

  task automatic wait_until(input int sel, input logic level, input string what);
    int n;
    n = 0;
    while (watch(sel) !== level) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) abort_on_timeout(what);
    end
  endtask

  // PHY model: turnaround, one byte with dir high, then release
  // With rx_data set the byte is receive data rather than an RX CMD
  task automatic phy_send(input ulpi_pkg::ulpi_byte_t b, input logic rx_data);
    ulpi_dir = 1'b1;
    ulpi_nxt = 1'b0;
    next_cycle();
    ulpi_data_in = b;
    ulpi_nxt = rx_data;
    next_cycle();
    ulpi_dir = 1'b0;
    ulpi_nxt = 1'b0;
    ulpi_data_in = '0;
    next_cycle();
  endtask

  // PHY model: take address and value on nxt, then expect one stp cycle
  task automatic accept_write(output ulpi_pkg::ulpi_byte_t cmd,
                              output ulpi_pkg::ulpi_byte_t val);
    int n;
    n = 0;
    while (ulpi_data_o == 8'h00) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) abort_on_timeout("no register write appeared on the bus");
    end
    cmd = ulpi_data_o;
    ulpi_nxt = 1'b1;
    next_cycle();
    val = ulpi_data_o;
    next_cycle();
    ulpi_nxt = 1'b0;
    n = 0;
    while (!ulpi_stp_o) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) abort_on_timeout("no stp after a register write");
    end
    next_cycle();
    check_bit("ulpi_stp_o", ulpi_stp_o, 1'b0);
  endtask

  // PHY model: take the bus back on the stp cycle of a write
  // The write then has to start over from the command byte
  task automatic interrupt_write(input ulpi_pkg::ulpi_byte_t exp_cmd);
    int n;
    n = 0;
    while (ulpi_data_o == 8'h00) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) abort_on_timeout("no register write to interrupt");
    end
    check_byte("ulpi_data_o command", ulpi_data_o, exp_cmd);
    ulpi_nxt = 1'b1;
    repeat (2) next_cycle();
    ulpi_nxt = 1'b0;
    check_bit("ulpi_stp_o", ulpi_stp_o, 1'b1);
    phy_send({6'b0, usb_link_pkg::LS_J}, 1'b0);
  endtask

  task automatic expect_write(input ulpi_pkg::ulpi_byte_t exp_cmd,
                              input ulpi_pkg::ulpi_byte_t exp_val);
    ulpi_pkg::ulpi_byte_t cmd;
    ulpi_pkg::ulpi_byte_t val;
    accept_write(cmd, val);
    check_byte("ulpi_data_o command", cmd, exp_cmd);
    check_byte("ulpi_data_o value", val, exp_val);
  endtask

  task automatic accept_nopid();
    int n;
    n = 0;
    while (ulpi_data_o == 8'h00) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) abort_on_timeout("no NOPID command for the chirp");
    end
    check_byte("ulpi_data_o", ulpi_data_o, ulpi_pkg::TX_NOPID);
    ulpi_nxt = 1'b1;
    next_cycle();
    ulpi_nxt = 1'b0;
  endtask

  // Start-up, SE0, chirp-K and a number of host K-J pairs
  task automatic run_chirp(input int pairs);
    int gap;
    apply_reset();
    expect_write(ulpi_pkg::REG_OTG_CTRL, ulpi_pkg::OTG_DEFAULT);
    expect_write(ulpi_pkg::REG_FUNC_CTRL, ulpi_pkg::FUNC_FS);
    phy_send({6'b0, usb_link_pkg::LS_SE0}, 1'b0);
    expect_write(ulpi_pkg::REG_FUNC_CTRL, ulpi_pkg::FUNC_CHIRP);
    accept_nopid();
    // Chirp-K ends 2 cycles after the 1 ms pulse
    wait_until(SEL_PULSE_1MS, 1'b1, "no 1 ms pulse during chirp-K");
    check_byte("ulpi_data_o tail", ulpi_data_o, 8'h00);
    next_cycle();
    check_bit("ulpi_stp_o", ulpi_stp_o, 1'b0);
    next_cycle();
    check_bit("ulpi_stp_o", ulpi_stp_o, 1'b1);
    next_cycle();
    check_bit("ulpi_stp_o", ulpi_stp_o, 1'b0);
    for (int i = 0; i < pairs; i++) begin
      phy_send({6'b0, usb_link_pkg::LS_K}, 1'b0);
      gap = 10 + ($unsigned($random(seed)) % 8);
      repeat (gap) next_cycle();
      phy_send({6'b0, usb_link_pkg::LS_J}, 1'b0);
      gap = 10 + ($unsigned($random(seed)) % 8);
      repeat (gap) next_cycle();
    end
  endtask

  task automatic send_and_decode(input ulpi_pkg::ulpi_byte_t b);
    phy_send(b, 1'b0);
    check_line("line_state_o", line_state_o, b[1:0]);
    check_line("vbus_state_o", vbus_state_o, b[3:2]);
    check_line("rx_event_o", rx_event_o, b[5:4]);
  endtask

  initial begin
    logic seen_hs;
    logic seen_write;
    int   ticks;
    int   n;
    clock = 1'b0;
    reset = 1'b1;
    ulpi_dir = 1'b0;
    ulpi_nxt = 1'b0;
    ulpi_data_in = '0;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    test_errors = 0;
    seed = 92127;

    apply_reset();
    check_line("line_state_o", line_state_o, usb_link_pkg::LS_J);
    // PHY grabs the bus during the first write, which is then sent again
    interrupt_write(ulpi_pkg::REG_OTG_CTRL);
    expect_write(ulpi_pkg::REG_OTG_CTRL, ulpi_pkg::OTG_DEFAULT);
    expect_write(ulpi_pkg::REG_FUNC_CTRL, ulpi_pkg::FUNC_FS);
    end_test("power_on");

    // Line stays off SE0 so no chirp starts
    send_and_decode(8'h2D);
    send_and_decode(8'h06);
    send_and_decode(8'h19);
    phy_send(8'h3E, 1'b1);
    check_line("line_state_o", line_state_o, 2'b01);
    check_line("vbus_state_o", vbus_state_o, 2'b10);
    check_line("rx_event_o", rx_event_o, 2'b01);
    end_test("rx_cmd_decode");

    // Two full 1 ms periods with the line idle at J
    wait_until(SEL_PULSE_1MS, 1'b1, "no 1 ms pulse with the line at J");
    for (int p = 0; p < 2; p++) begin
      ticks = 0;
      n = 0;
      next_cycle();
      while (!pulse_1ms_o) begin
        if (pulse_2_5us_o) ticks++;
        next_cycle();
        n++;
        if (n > WAIT_LIMIT) abort_on_timeout("1 ms pulse stopped firing");
      end
      check_count_value("ticks per pulse_1ms_o", ticks, usb_link_pkg::TICKS_1MS);
      check_bit("high_speed_o", high_speed_o, 1'b0);
    end
    end_test("no_host_chirp");

    run_chirp(2);
    seen_hs = 1'b0;
    seen_write = 1'b0;
    repeat (400) begin
      next_cycle();
      if (high_speed_o) seen_hs = 1'b1;
      if (ulpi_data_o != 8'h00) seen_write = 1'b1;
    end
    check_bit("high_speed_o", seen_hs, 1'b0);
    check_bit("ulpi_data_o active", seen_write, 1'b0);
    end_test("partial_chirp");

    run_chirp(usb_link_pkg::KJ_PAIRS);
    expect_write(ulpi_pkg::REG_FUNC_CTRL, ulpi_pkg::FUNC_HS);
    wait_until(SEL_HIGH_SPEED, 1'b1, "high_speed_o never rose");
    check_bit("usb_reset_o", usb_reset_o, 1'b0);
    end_test("high_speed_chirp");

    // Host holds SE0, then the line returns to J
    phy_send({6'b0, usb_link_pkg::LS_SE0}, 1'b0);
    wait_until(SEL_USB_RESET, 1'b1, "usb_reset_o never rose on SE0");
    phy_send({6'b0, usb_link_pkg::LS_J}, 1'b0);
    expect_write(ulpi_pkg::REG_FUNC_CTRL, ulpi_pkg::FUNC_FS);
    wait_until(SEL_USB_RESET, 1'b0, "usb_reset_o stayed high after the reset");
    check_bit("high_speed_o", high_speed_o, 1'b0);
    end_test("bus_reset");

    wait_until(SEL_SUSPEND, 1'b1, "suspend_o never rose with the line at J");
    phy_send({6'b0, usb_link_pkg::LS_K}, 1'b0);
    next_cycle();
    check_bit("suspend_o", suspend_o, 1'b0);
    end_test("suspend");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- list.f
common/ulpi_pkg.sv
common/usb_link_pkg.sv
rtl/ulpi_rx_capture.sv
rtl/line_timers.sv
speed_negotiator/speed_negotiator.sv
rtl/ulpi_transmitter.sv
rtl/ulpi_line_ctrl.sv
verification/ulpi_line_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f \
  --top-module ulpi_line_ctrl_tb -o ulpi_line_ctrl_sim

./obj_dir/ulpi_line_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then
  exit 1
fi
exit 0
